//--- hdl/ooo_pkg.sv
// Shared widths, sizes and micro-op payload types for the issue stage; import where needed.
package ooo_pkg;

    // Physical register file.
    localparam int PREG_W    = 6;
    localparam int NUM_PREGS = 1 << PREG_W;

    // Dispatch width per buffer and the matching count width.
    localparam int PUSH_WIDTH = 2;
    localparam int CT_W       = $clog2(PUSH_WIDTH) + 1;

    // Both buffers together can allocate this many destinations per cycle.
    localparam int ALLOC_N = 2 * PUSH_WIDTH;

    // Buffer depths, also the initial credit counts.
    localparam int ALU_ENTRIES = 4;
    localparam int MEM_ENTRIES = 4;

    // Cycles from issue to the destination done bit, at least 2.
    localparam int WB_LAT = 2;

    localparam int TAG_W    = 8;  // Sequence tag for tracking.
    localparam int OPCODE_W = 6;
    localparam int OFFSET_W = 12;

    // ALU micro-op payload.
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [PREG_W-1:0]   dst;
        logic [OPCODE_W-1:0] opcode;
    } alu_uop_t;

    // Memory micro-op payload.
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [PREG_W-1:0]   dst;
        logic                is_store;
        logic [OFFSET_W-1:0] offset;
    } mem_uop_t;

    // The issue bus carries the wider of the two payloads.
    localparam int ISSUE_DATA_W = $bits(mem_uop_t);

    // Which buffer owns an issue-bus transfer.
    typedef enum logic {
        CLASS_ALU = 1'b0,
        CLASS_MEM = 1'b1
    } issue_class_e;

endpackage

//--- hdl/issue_entry.sv
// Single issue slot: stores one micro-op with its source tags and flags it when sources are done.
`timescale 1ns/1ps

module issue_entry #(
    parameter type uop_t = ooo_pkg::alu_uop_t
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [ooo_pkg::NUM_PREGS-1:0] done_flags,
    input  logic                         wr_en,
    input  uop_t                         wr_payload,
    input  logic [ooo_pkg::PREG_W-1:0]   wr_src1,
    input  logic [ooo_pkg::PREG_W-1:0]   wr_src2,
    input  logic                         clear,
    output uop_t                         payload,
    output logic                         busy,
    output logic                         ready
);
    import ooo_pkg::*;

    logic              busy_q;
    uop_t              payload_q;
    logic [PREG_W-1:0] src1_q;
    logic [PREG_W-1:0] src2_q;

    // Occupancy.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (wr_en) begin
            busy_q <= 1'b1;
        end else if (clear) begin
            busy_q <= 1'b0;
        end
    end

    // Payload and tags only load on a write.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            payload_q <= wr_payload;
            src1_q    <= wr_src1;
            src2_q    <= wr_src2;
        end
    end

    assign payload = payload_q;
    assign busy    = busy_q;
    assign ready   = busy_q && done_flags[src1_q] && done_flags[src2_q];

endmodule

//--- hdl/issue_buffer_ooo.sv
// Issue buffer holding ELEMENTS micro-ops of one kind; requests its lowest ready slot for issue.
`timescale 1ns/1ps

module issue_buffer_ooo #(
    parameter type uop_t    = ooo_pkg::alu_uop_t,
    parameter int  ELEMENTS = ooo_pkg::ALU_ENTRIES
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  uop_t                          din [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]    din_src1 [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]    din_src2 [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::CT_W-1:0]      din_valid_ct,
    output logic                          credit_return,
    input  logic [ooo_pkg::NUM_PREGS-1:0] done_flags,
    output logic                          req,
    output uop_t                          req_payload,
    input  logic                          grant
);
    import ooo_pkg::*;

    localparam int SEL_W = (ELEMENTS > 1) ? $clog2(ELEMENTS) : 1;

    logic [ELEMENTS-1:0] wr_en;
    logic [ELEMENTS-1:0] clear;
    logic [ELEMENTS-1:0] busy;
    logic [ELEMENTS-1:0] ready;
    uop_t                wr_payload [ELEMENTS];
    logic [PREG_W-1:0]   wr_src1 [ELEMENTS];
    logic [PREG_W-1:0]   wr_src2 [ELEMENTS];
    uop_t                entry_payload [ELEMENTS];
    logic [SEL_W-1:0]    sel;

    for (genvar g = 0; g < ELEMENTS; g++) begin : g_entry
        issue_entry #(
            .uop_t (uop_t)
        ) i_issue_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .done_flags (done_flags),
            .wr_en      (wr_en[g]),
            .wr_payload (wr_payload[g]),
            .wr_src1    (wr_src1[g]),
            .wr_src2    (wr_src2[g]),
            .clear      (clear[g]),
            .payload    (entry_payload[g]),
            .busy       (busy[g]),
            .ready      (ready[g])
        );
    end

    // Valid lanes go into free slots in lane order, lowest slot first.
    always_comb begin
        int unsigned lane;
        lane  = 0;
        wr_en = '0;
        for (int i = 0; i < ELEMENTS; i++) begin
            wr_payload[i] = din[0];
            wr_src1[i]    = din_src1[0];
            wr_src2[i]    = din_src2[0];
            if (!busy[i] && lane < din_valid_ct && lane < PUSH_WIDTH) begin
                wr_en[i]      = 1'b1;
                wr_payload[i] = din[lane];
                wr_src1[i]    = din_src1[lane];
                wr_src2[i]    = din_src2[lane];
                lane          = lane + 1;
            end
        end
    end

    // Priority encoder, lowest ready index wins.
    always_comb begin
        sel = '0;
        req = 1'b0;
        for (int i = ELEMENTS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel = SEL_W'(i);
                req = 1'b1;
            end
        end
    end

    assign req_payload = entry_payload[sel];

    always_comb begin
        clear = '0;
        if (grant && req) begin
            clear[sel] = 1'b1;  // Freed at the end of the issue cycle.
        end
    end

    // One credit per freed slot, a cycle after issue.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= grant && req;
        end
    end

endmodule

//--- hdl/issue_arbiter.sv
// Two-way round-robin arbiter giving the shared issue bus to the ALU or memory buffer.
`timescale 1ns/1ps

module issue_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_alu,
    input  logic                  req_mem,
    output logic                  grant_alu,
    output logic                  grant_mem,
    output ooo_pkg::issue_class_e grant_class
);
    import ooo_pkg::*;

    logic mem_first;  // Set when memory has priority in a tie.

    always_comb begin
        grant_alu = req_alu && (!req_mem || !mem_first);
        grant_mem = req_mem && (!req_alu || mem_first);
        if (grant_mem) begin
            grant_class = CLASS_MEM;
        end else begin
            grant_class = CLASS_ALU;
        end
    end

    // Flip only after a contested grant.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_first <= 1'b0;
        end else if (req_alu && req_mem) begin
            mem_first <= !mem_first;
        end
    end

endmodule

//--- hdl/done_tracker.sv
// Per-register done bits: cleared on dispatch, set WB_LAT cycles after the producer issues.
`timescale 1ns/1ps

module done_tracker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [ooo_pkg::PREG_W-1:0]    alloc_dst [ooo_pkg::ALLOC_N],
    input  logic [ooo_pkg::ALLOC_N-1:0]   alloc_valid,
    input  logic                          issue_fire,
    input  logic [ooo_pkg::PREG_W-1:0]    issue_dst,
    output logic [ooo_pkg::NUM_PREGS-1:0] done_flags
);
    import ooo_pkg::*;

    // The done register itself is the last stage of the writeback delay.
    localparam int PIPE_D = WB_LAT - 1;

    logic                 pipe_vld [PIPE_D];
    logic [PREG_W-1:0]    pipe_dst [PIPE_D];
    logic [NUM_PREGS-1:0] set_vec;
    logic [NUM_PREGS-1:0] clr_vec;
    logic [NUM_PREGS-1:0] done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < PIPE_D; i++) begin
                pipe_vld[i] <= 1'b0;
            end
        end else begin
            pipe_vld[0] <= issue_fire;
            for (int i = 1; i < PIPE_D; i++) begin
                pipe_vld[i] <= pipe_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pipe_dst[0] <= issue_dst;
        for (int i = 1; i < PIPE_D; i++) begin
            pipe_dst[i] <= pipe_dst[i-1];
        end
    end

    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        if (pipe_vld[PIPE_D-1]) begin
            set_vec[pipe_dst[PIPE_D-1]] = 1'b1;
        end
        for (int i = 0; i < ALLOC_N; i++) begin
            if (alloc_valid[i]) begin
                clr_vec[alloc_dst[i]] = 1'b1;
            end
        end
    end

    // Clear beats set on the same register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= '1;
        end else begin
            done_q <= (done_q | set_vec) & ~clr_vec;
        end
    end

    assign done_flags = done_q;

endmodule

//--- hdl/issue_top.sv
// Issue stage top: ALU and memory buffers, round-robin arbiter, done tracker and issue bus.
`timescale 1ns/1ps

module issue_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  ooo_pkg::alu_uop_t                alu_din [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]       alu_din_src1 [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]       alu_din_src2 [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]       alu_din_dst [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::CT_W-1:0]         alu_din_valid_ct,
    output logic                             alu_credit_return,
    input  ooo_pkg::mem_uop_t                mem_din [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]       mem_din_src1 [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]       mem_din_src2 [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::PREG_W-1:0]       mem_din_dst [ooo_pkg::PUSH_WIDTH],
    input  logic [ooo_pkg::CT_W-1:0]         mem_din_valid_ct,
    output logic                             mem_credit_return,
    output logic                             issue_valid,
    output ooo_pkg::issue_class_e            issue_class,
    output logic [ooo_pkg::TAG_W-1:0]        issue_tag,
    output logic [ooo_pkg::PREG_W-1:0]       issue_dst,
    output logic [ooo_pkg::ISSUE_DATA_W-1:0] issue_data
);
    import ooo_pkg::*;

    logic               alu_req, mem_req;
    logic               alu_grant, mem_grant;
    alu_uop_t           alu_req_payload;
    mem_uop_t           mem_req_payload;
    issue_class_e       grant_class;
    logic [NUM_PREGS-1:0] done_flags;
    logic [PREG_W-1:0]  alloc_dst [ALLOC_N];
    logic [ALLOC_N-1:0] alloc_valid;

    // ALU lanes first, then memory lanes.
    for (genvar g = 0; g < PUSH_WIDTH; g++) begin : g_alloc
        assign alloc_dst[g]              = alu_din_dst[g];
        assign alloc_dst[g+PUSH_WIDTH]   = mem_din_dst[g];
        assign alloc_valid[g]            = g < alu_din_valid_ct;
        assign alloc_valid[g+PUSH_WIDTH] = g < mem_din_valid_ct;
    end

    issue_buffer_ooo #(.uop_t(alu_uop_t), .ELEMENTS(ALU_ENTRIES)) i_alu_buffer (
        .clk (clk), .rst_n (rst_n),
        .din (alu_din), .din_src1 (alu_din_src1), .din_src2 (alu_din_src2),
        .din_valid_ct (alu_din_valid_ct), .credit_return (alu_credit_return),
        .done_flags (done_flags),
        .req (alu_req), .req_payload (alu_req_payload), .grant (alu_grant)
    );

    issue_buffer_ooo #(.uop_t(mem_uop_t), .ELEMENTS(MEM_ENTRIES)) i_mem_buffer (
        .clk (clk), .rst_n (rst_n),
        .din (mem_din), .din_src1 (mem_din_src1), .din_src2 (mem_din_src2),
        .din_valid_ct (mem_din_valid_ct), .credit_return (mem_credit_return),
        .done_flags (done_flags),
        .req (mem_req), .req_payload (mem_req_payload), .grant (mem_grant)
    );

    issue_arbiter i_issue_arbiter (
        .clk (clk), .rst_n (rst_n),
        .req_alu (alu_req), .req_mem (mem_req),
        .grant_alu (alu_grant), .grant_mem (mem_grant), .grant_class (grant_class)
    );

    done_tracker i_done_tracker (
        .clk (clk), .rst_n (rst_n),
        .alloc_dst (alloc_dst), .alloc_valid (alloc_valid),
        .issue_fire (issue_valid), .issue_dst (issue_dst), .done_flags (done_flags)
    );

    // Issue bus mux, ALU payload zero-extended.
    always_comb begin
        issue_valid = alu_grant || mem_grant;
        issue_class = grant_class;
        if (mem_grant) begin
            issue_tag  = mem_req_payload.tag;
            issue_dst  = mem_req_payload.dst;
            issue_data = mem_req_payload;
        end else begin
            issue_tag  = alu_req_payload.tag;
            issue_dst  = alu_req_payload.dst;
            issue_data = ISSUE_DATA_W'(alu_req_payload);
        end
    end

endmodule

//--- verification/issue_tb.sv
// Simulation top that drives random dispatch under credits and checks the issue bus.
`timescale 1ns/1ps

module issue_tb;
    import ooo_pkg::*;

    localparam int NUM_UOPS        = 300;
    localparam int DISPATCH_CYCLES = 2000;
    localparam int TIMEOUT_CYCLES  = 2 * DISPATCH_CYCLES;  // Dispatch window plus a full drain.

    logic                    clk;
    logic                    rst_n;
    alu_uop_t                alu_din [PUSH_WIDTH];
    mem_uop_t                mem_din [PUSH_WIDTH];
    logic [PREG_W-1:0]       alu_din_src1 [PUSH_WIDTH], alu_din_src2 [PUSH_WIDTH];
    logic [PREG_W-1:0]       mem_din_src1 [PUSH_WIDTH], mem_din_src2 [PUSH_WIDTH];
    logic [PREG_W-1:0]       alu_din_dst [PUSH_WIDTH], mem_din_dst [PUSH_WIDTH];
    logic [CT_W-1:0]         alu_din_valid_ct, mem_din_valid_ct;
    logic                    alu_credit_return, mem_credit_return;
    logic                    issue_valid;
    issue_class_e            issue_class;
    logic [TAG_W-1:0]        issue_tag;
    logic [PREG_W-1:0]       issue_dst;
    logic [ISSUE_DATA_W-1:0] issue_data;

    // Scoreboard indexed by tag.
    logic                    pending [256];
    issue_class_e            exp_class [256];
    logic [PREG_W-1:0]       exp_dst [256], src1_of [256], src2_of [256];
    logic [ISSUE_DATA_W-1:0] exp_data [256];

    // Register model.
    logic [NUM_PREGS-1:0]    done_ref;
    logic                    dst_pending [NUM_PREGS];  // Allocated and not yet written back.
    int                      src_refs [NUM_PREGS];
    logic                    wb_vld [WB_LAT-1];
    logic [PREG_W-1:0]       wb_dst [WB_LAT-1];

    int           seed, seq, cycle, pushed_total, issued_total;
    int           alu_credits, mem_credits, value_errors, other_errors;
    logic         mem_turn, prev_valid;
    issue_class_e prev_class;
    logic [PREG_W-1:0] last_dst;

    issue_top i_issue_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected done vector for the next cycle; a dispatch clear beats a writeback set.
    function automatic logic [NUM_PREGS-1:0] next_done(input logic [NUM_PREGS-1:0] cur,
            input logic set_vld, input logic [PREG_W-1:0] set_dst,
            input logic [NUM_PREGS-1:0] clr);
        logic [NUM_PREGS-1:0] set;
        set = '0;
        if (set_vld) begin
            set[set_dst] = 1'b1;
        end
        return (cur | set) & ~clr;
    endfunction

    function automatic logic class_ready(input issue_class_e cls);
        for (int i = 0; i < 256; i++) begin
            if (pending[i] && exp_class[i] == cls
                    && done_ref[src1_of[i]] && done_ref[src2_of[i]]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic [PREG_W-1:0] free_dst();
        int start;
        int r;
        start = {$random(seed)} % NUM_PREGS;
        for (int i = 0; i < NUM_PREGS; i++) begin
            r = (start + i) % NUM_PREGS;
            if (!dst_pending[r] && src_refs[r] == 0) begin
                return PREG_W'(r);
            end
        end
        return '0;
    endfunction

    function automatic int push_count(input int credits);
        int n;
        n = 0;
        if ({$random(seed)} % 16 == 0) begin
            n = 1 + {$random(seed)} % PUSH_WIDTH;
        end
        if (n > credits) n = credits;
        if (n > NUM_UOPS - seq) n = NUM_UOPS - seq;
        return n;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Builds one micro-op on a lane; source 1 often depends on the last destination.
    task fill_lane(input issue_class_e cls, input int lane);
        logic [PREG_W-1:0] s1, s2, d;
        alu_uop_t a;
        mem_uop_t m;
        s1 = ($random(seed) & 1) ? last_dst : PREG_W'($random(seed));
        s2 = PREG_W'($random(seed));
        src_refs[s1]++;
        src_refs[s2]++;
        d = free_dst();
        dst_pending[d] = 1'b1;
        last_dst = d;
        if (cls == CLASS_ALU) begin
            a.tag = TAG_W'(seq);
            a.dst = d;
            a.opcode = OPCODE_W'($random(seed));
            alu_din[lane] <= a;
            alu_din_src1[lane] <= s1;
            alu_din_src2[lane] <= s2;
            alu_din_dst[lane] <= d;
        end else begin
            m.tag = TAG_W'(seq);
            m.dst = d;
            m.is_store = $random(seed) & 1;
            m.offset = OFFSET_W'($random(seed));
            mem_din[lane] <= m;
            mem_din_src1[lane] <= s1;
            mem_din_src2[lane] <= s2;
            mem_din_dst[lane] <= d;
        end
        seq++;
    endtask

    task automatic record_push(input logic [TAG_W-1:0] t, input issue_class_e cls,
            input logic [PREG_W-1:0] dst, input logic [PREG_W-1:0] s1,
            input logic [PREG_W-1:0] s2, input logic [ISSUE_DATA_W-1:0] data);
        pending[t]   = 1'b1;
        exp_class[t] = cls;
        exp_dst[t]   = dst;
        src1_of[t]   = s1;
        src2_of[t]   = s2;
        exp_data[t]  = data;
        pushed_total++;
    endtask

    always @(posedge clk) begin : drive_dispatch
        int n_alu;
        int n_mem;
        n_alu = 0;
        n_mem = 0;
        if (rst_n && cycle < DISPATCH_CYCLES) begin
            n_alu = push_count(alu_credits);
            alu_credits -= n_alu;
            for (int l = 0; l < n_alu; l++) fill_lane(CLASS_ALU, l);
            n_mem = push_count(mem_credits);
            mem_credits -= n_mem;
            for (int l = 0; l < n_mem; l++) fill_lane(CLASS_MEM, l);
        end
        alu_din_valid_ct <= CT_W'(n_alu);
        mem_din_valid_ct <= CT_W'(n_mem);
    end

    // Outputs and the pushes about to be captured are stable at the falling edge.
    always @(negedge clk) begin : compare_bus
        logic alu_rdy;
        logic mem_rdy;
        logic fired;
        logic [TAG_W-1:0] t;
        logic [NUM_PREGS-1:0] clr;
        if (rst_n) begin
            cycle++;
            alu_rdy = class_ready(CLASS_ALU);
            mem_rdy = class_ready(CLASS_MEM);
            if (pushed_total == 0) begin
                assert (!issue_valid && !alu_credit_return && !mem_credit_return) else begin
                    $display("Issue bus or credit active at %0t before the first push", $time);
                    other_errors++;
                end
            end
            compare_value("issue_valid", issue_valid, alu_rdy || mem_rdy);
            if (alu_rdy && mem_rdy) begin
                compare_value("issue_class", issue_class, mem_turn);  // Contested grant.
                mem_turn = !mem_turn;
            end
            t = issue_tag;
            fired = issue_valid && pending[t];
            if (issue_valid) begin
                assert (pending[t]) else begin
                    $display("Tag %0d issued at %0t but is not waiting", t, $time);
                    other_errors++;
                end
            end
            if (fired) begin
                compare_value("issue_class", issue_class, exp_class[t]);
                compare_value("issue_dst", issue_dst, exp_dst[t]);
                compare_value("issue_data", issue_data, exp_data[t]);
                assert (done_ref[src1_of[t]] && done_ref[src2_of[t]]) else begin
                    $display("Tag %0d issued at %0t before its sources were done", t, $time);
                    other_errors++;
                end
                pending[t] = 1'b0;
                src_refs[src1_of[t]]--;
                src_refs[src2_of[t]]--;
                issued_total++;
            end
            compare_value("alu_credit_return", alu_credit_return,
                          prev_valid && prev_class == CLASS_ALU);
            compare_value("mem_credit_return", mem_credit_return,
                          prev_valid && prev_class == CLASS_MEM);
            alu_credits += alu_credit_return;
            mem_credits += mem_credit_return;
            assert (alu_credits >= 0 && alu_credits <= ALU_ENTRIES
                    && mem_credits >= 0 && mem_credits <= MEM_ENTRIES) else begin
                $display("Credit count out of range at %0t", $time);
                other_errors++;
            end
            prev_valid = fired;
            prev_class = exp_class[t];
            clr = '0;
            for (int l = 0; l < PUSH_WIDTH; l++) begin
                if (l < alu_din_valid_ct) begin
                    record_push(alu_din[l].tag, CLASS_ALU, alu_din[l].dst, alu_din_src1[l],
                                alu_din_src2[l], ISSUE_DATA_W'(alu_din[l]));
                    clr[alu_din_dst[l]] = 1'b1;
                end
                if (l < mem_din_valid_ct) begin
                    record_push(mem_din[l].tag, CLASS_MEM, mem_din[l].dst, mem_din_src1[l],
                                mem_din_src2[l], mem_din[l]);
                    clr[mem_din_dst[l]] = 1'b1;
                end
            end
            done_ref = next_done(done_ref, wb_vld[WB_LAT-2], wb_dst[WB_LAT-2], clr);
            if (wb_vld[WB_LAT-2]) begin
                dst_pending[wb_dst[WB_LAT-2]] = 1'b0;
            end
            for (int i = WB_LAT - 2; i > 0; i--) begin
                wb_vld[i] = wb_vld[i-1];
                wb_dst[i] = wb_dst[i-1];
            end
            wb_vld[0] = fired;
            wb_dst[0] = exp_dst[t];
        end
    end

    initial begin : run
        seed = 32'ha260_6e7b;
        rst_n = 1'b0;
        alu_din = '{default: '0};
        mem_din = '{default: '0};
        alu_din_src1 = '{default: '0};
        alu_din_src2 = '{default: '0};
        alu_din_dst = '{default: '0};
        mem_din_src1 = '{default: '0};
        mem_din_src2 = '{default: '0};
        mem_din_dst = '{default: '0};
        alu_din_valid_ct = '0;
        mem_din_valid_ct = '0;
        pending = '{default: 1'b0};
        dst_pending = '{default: 1'b0};
        src_refs = '{default: 0};
        wb_vld = '{default: 1'b0};
        wb_dst = '{default: '0};
        done_ref = '1;
        alu_credits = ALU_ENTRIES;
        mem_credits = MEM_ENTRIES;
        {seq, cycle, pushed_total, issued_total, value_errors, other_errors} = '0;
        {mem_turn, prev_valid, last_dst} = '0;
        prev_class = CLASS_ALU;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (!((cycle >= DISPATCH_CYCLES || pushed_total >= NUM_UOPS)
                 && issued_total == pushed_total) && cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d micro-ops issued",
                     cycle, issued_total, pushed_total);
            other_errors++;
        end else begin
            repeat (WB_LAT + 2) @(posedge clk);  // Let the last credits come back.
            assert (alu_credits == ALU_ENTRIES && mem_credits == MEM_ENTRIES) else begin
                $display("Credits not back to full: alu %0d mem %0d", alu_credits, mem_credits);
                other_errors++;
            end
        end
        $display("Pushed %0d issued %0d, errors: %0d value, %0d other",
                 pushed_total, issued_total, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/ooo_pkg.sv
hdl/issue_entry.sv
hdl/issue_buffer_ooo.sv
hdl/issue_arbiter.sv
hdl/done_tracker.sv
hdl/issue_top.sv
verification/issue_tb.sv
